// File: hdl/mod241_pkg.sv
`default_nettype none

package mod241_pkg;

  // Bit 1 of the operand carries weight 2^0
  typedef logic [100:1] operand_t;
  typedef logic [7:0]   residue_t;
  typedef logic [7:0]   apb_addr_t;
  typedef logic [31:0]  apb_data_t;
  typedef logic [1:0]   word_idx_t;

  localparam logic [7:0] MODULUS = 8'd241;

  // 2^8 mod 241
  localparam logic [3:0] FOLD_FACTOR = 4'd15;

  // Register map
  localparam apb_addr_t ADDR_OPERAND = 8'h00;
  localparam apb_addr_t ADDR_CTRL    = 8'h04;
  localparam apb_addr_t ADDR_STATUS  = 8'h08;
  localparam apb_addr_t ADDR_RESULT  = 8'h0C;

  // STATUS bit positions
  localparam int STAT_BUSY   = 0;
  localparam int STAT_DONE   = 1;
  localparam int STAT_LOADED = 2;

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } fsm_state_t;

endpackage

`default_nettype wire

// File: hdl/residue_ctrl_if.sv
`default_nettype none

interface residue_ctrl_if import mod241_pkg::*; ();

  logic      word_wr;
  logic      start;
  logic      loaded;
  logic      clear_words;
  logic      busy;
  logic      done;
  word_idx_t word_idx;
  residue_t  result;

  modport regs (
    output word_wr, start,
    input  loaded, busy, done, result, word_idx
  );

  modport fsm (
    input  start, word_wr,
    output busy, done, clear_words, result
  );

  modport counter (
    input  word_wr, clear_words,
    output loaded, word_idx
  );

endinterface

`default_nettype wire

// File: hdl/chunk_residue.sv
`default_nettype none

module chunk_residue import mod241_pkg::*; #(
  parameter int CHUNK_POS = 7
) (
  input  logic [5:0] chunk,
  output residue_t   residue
);

  function automatic int pow2_mod(input int exp);
    int w;
    w = 1;
    for (int k = 0; k < exp; k++)
    begin
      w = (w * 2) % int'(MODULUS);
    end
    return w;
  endfunction

  // Bit numbering starts at 1, so the chunk weight is 2^(CHUNK_POS-1)
  localparam logic [7:0] WEIGHT = 8'(pow2_mod(CHUNK_POS - 1));

  logic [13:0] product;

  assign product = 14'(chunk) * 14'(WEIGHT);

  // Constant divisor, folds into a small table
  assign residue = residue_t'(product % 14'(MODULUS));

endmodule

`default_nettype wire

// File: hdl/x_100_mod_241.sv
`default_nettype none

module x_100_mod_241 import mod241_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  operand_t operand,
  output logic     out_valid,
  output residue_t residue
);

  residue_t    r [16];
  logic [9:0]  grp [5];
  logic [10:0] sum_lo_d;
  logic [10:0] sum_hi_d;

  logic [10:0] sum_lo_q;
  logic [10:0] sum_hi_q;
  logic [5:0]  head_q;
  logic        valid_q;

  logic [9:0]  fold1;
  logic [8:0]  fold2;
  residue_t    residue_d;

  // Fifteen full chunks above the 6-bit head
  for (genvar i = 0; i < 15; i++)
  begin : g_chunk
    chunk_residue #(
      .CHUNK_POS (7 + 6 * i)
    ) i_chunk_residue (
      .chunk   (operand[12 + 6 * i -: 6]),
      .residue (r[i])
    );
  end

  // Only four operand bits remain for the top chunk
  chunk_residue #(
    .CHUNK_POS (97)
  ) i_chunk_residue_top (
    .chunk   ({2'b00, operand[100:97]}),
    .residue (r[15])
  );

  for (genvar g = 0; g < 5; g++)
  begin : g_group
    assign grp[g] = 10'(r[3 * g]) + 10'(r[3 * g + 1]) + 10'(r[3 * g + 2]);
  end

  // Weights repeat every 24 bits, nine residues stay under 2048
  assign sum_lo_d = 11'(grp[0]) + 11'(grp[1]) + 11'(grp[2]);
  assign sum_hi_d = 11'(grp[3]) + 11'(grp[4]) + 11'(r[15]);

  always_ff @(posedge clk)
  begin
    if (rst)
      valid_q <= 1'b0;
    else
      valid_q <= in_valid;
  end

  always_ff @(posedge clk)
  begin
    sum_lo_q <= sum_lo_d;
    sum_hi_q <= sum_hi_d;
    head_q   <= operand[6:1];
  end

  // Bits 7 and 8 keep weight 64, bits 9 and up reduce by 15
  assign fold1 = 10'(sum_lo_q[5:0]) + 10'({sum_lo_q[7:6], 6'b0})
               + 10'(FOLD_FACTOR) * 10'(sum_lo_q[10:8])
               + 10'(sum_hi_q[5:0]) + 10'({sum_hi_q[7:6], 6'b0})
               + 10'(FOLD_FACTOR) * 10'(sum_hi_q[10:8]);

  assign fold2 = 9'(fold1[5:0]) + 9'({fold1[7:6], 6'b0})
               + 9'(FOLD_FACTOR) * 9'(fold1[9:8]) + 9'(head_q);

  // fold2 stays below 482, one subtraction is enough
  always_comb
  begin
    if (fold2 >= 9'(MODULUS))
      residue_d = residue_t'(fold2 - 9'(MODULUS));
    else
      residue_d = residue_t'(fold2);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      out_valid <= 1'b0;
    else
      out_valid <= valid_q;
  end

  always_ff @(posedge clk)
  begin
    residue <= residue_d;
  end

endmodule

`default_nettype wire

// File: hdl/operand_word_counter.sv
`default_nettype none

module operand_word_counter import mod241_pkg::*; #(
  parameter int NUM_WORDS = 4
) (
  input logic          clk,
  input logic          rst,
  residue_ctrl_if.counter ctrl
);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ctrl.word_idx <= '0;
      ctrl.loaded   <= 1'b0;
    end
    else if (ctrl.clear_words)
    begin
      ctrl.word_idx <= '0;
      ctrl.loaded   <= 1'b0;
    end
    else if (ctrl.word_wr)
    begin
      if (ctrl.word_idx == word_idx_t'(NUM_WORDS - 1))
      begin
        // Stays loaded until the next launch
        ctrl.word_idx <= '0;
        ctrl.loaded   <= 1'b1;
      end
      else
        ctrl.word_idx <= ctrl.word_idx + word_idx_t'(1);
    end
  end

endmodule

`default_nettype wire

// File: hdl/residue_fsm.sv
`default_nettype none

module residue_fsm import mod241_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  residue_ctrl_if.fsm ctrl,
  output logic     in_valid,
  input  logic     out_valid,
  input  residue_t residue
);

  fsm_state_t state;
  fsm_state_t state_next;
  logic       launch;

  // Operand is issued on the same edge that enters CALC
  assign launch = (state == IDLE) && ctrl.start;

  assign in_valid         = launch;
  assign ctrl.clear_words = launch;
  assign ctrl.busy        = (state == CALC);
  assign ctrl.done        = (state == DONE);

  always_comb
  begin
    state_next = state;
    case (state)
      IDLE:
      begin
        if (ctrl.start)
          state_next = CALC;
      end
      CALC:
      begin
        if (out_valid)
          state_next = DONE;
      end
      DONE:
      begin
        // Next operand word starts a new round
        if (ctrl.word_wr)
          state_next = IDLE;
      end
      default:
        state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= IDLE;
    else
      state <= state_next;
  end

  // Residue of the last finished operand
  always_ff @(posedge clk)
  begin
    if (rst)
      ctrl.result <= '0;
    else if ((state == CALC) && out_valid)
      ctrl.result <= residue;
  end

endmodule

`default_nettype wire

// File: hdl/apb_regs.sv
`default_nettype none

module apb_regs import mod241_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr,
  residue_ctrl_if.regs ctrl,
  output operand_t  operand
);

  apb_data_t op_word [3];
  logic [3:0] op_top;

  logic      access;
  logic      addr_ok;
  logic      start_req;
  logic      start_err;
  logic      word_err;
  logic      word_ok;
  logic      start_ok;
  apb_data_t rdata;

  // No wait states
  assign pready = 1'b1;
  assign access = psel && penable;

  always_comb
  begin
    addr_ok = paddr inside {ADDR_OPERAND, ADDR_CTRL, ADDR_STATUS, ADDR_RESULT};
  end

  assign start_req = pwrite && (paddr == ADDR_CTRL) && pwdata[0];
  assign start_err = start_req && (!ctrl.loaded || ctrl.busy);
  assign word_err  = pwrite && (paddr == ADDR_OPERAND) && ctrl.busy;

  assign pslverr  = access && (!addr_ok || start_err || word_err);
  assign word_ok  = access && pwrite && (paddr == ADDR_OPERAND) && !ctrl.busy;
  assign start_ok = access && start_req && !start_err;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ctrl.word_wr <= 1'b0;
      ctrl.start   <= 1'b0;
    end
    else
    begin
      ctrl.word_wr <= word_ok;
      ctrl.start   <= start_ok;
    end
  end

  // Word 3 holds operand bits 100 to 97 only
  always_ff @(posedge clk)
  begin
    if (word_ok)
    begin
      case (ctrl.word_idx)
        2'd0: op_word[0] <= pwdata;
        2'd1: op_word[1] <= pwdata;
        2'd2: op_word[2] <= pwdata;
        default: op_top  <= pwdata[3:0];
      endcase
    end
  end

  assign operand = {op_top, op_word[2], op_word[1], op_word[0]};

  always_comb
  begin
    rdata = '0;
    case (paddr)
      ADDR_STATUS:
      begin
        rdata[STAT_BUSY]   = ctrl.busy;
        rdata[STAT_DONE]   = ctrl.done;
        rdata[STAT_LOADED] = ctrl.loaded;
      end
      ADDR_RESULT:
        rdata = apb_data_t'(ctrl.result);
      default:
        rdata = '0;
    endcase
  end

  // Captured in the setup phase, held through the enable phase
  always_ff @(posedge clk)
  begin
    if (rst)
      prdata <= '0;
    else if (psel && !penable && !pwrite)
      prdata <= rdata;
  end

endmodule

`default_nettype wire

// File: hdl/mod241_apb_top.sv
`default_nettype none

module mod241_apb_top import mod241_pkg::*; #(
  parameter int NUM_WORDS = 4
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr
);

  residue_ctrl_if ctrl_if ();

  operand_t operand;
  logic     core_in_valid;
  logic     core_out_valid;
  residue_t core_residue;

  apb_regs i_apb_regs (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .ctrl    (ctrl_if.regs),
    .operand (operand)
  );

  operand_word_counter #(
    .NUM_WORDS (NUM_WORDS)
  ) i_operand_word_counter (
    .clk  (clk),
    .rst  (rst),
    .ctrl (ctrl_if.counter)
  );

  residue_fsm i_residue_fsm (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (ctrl_if.fsm),
    .in_valid  (core_in_valid),
    .out_valid (core_out_valid),
    .residue   (core_residue)
  );

  x_100_mod_241 i_x_100_mod_241 (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (core_in_valid),
    .operand   (operand),
    .out_valid (core_out_valid),
    .residue   (core_residue)
  );

endmodule

`default_nettype wire

// File: testbench/mod241_props.sv
`default_nettype none

module mod241_props import mod241_pkg::*; (
  input logic      clk,
  input logic      rst,
  input logic      psel,
  input logic      penable,
  input logic      pwrite,
  input apb_addr_t paddr,
  input apb_data_t pwdata,
  input apb_data_t prdata,
  input logic      pready,
  input logic      pslverr,
  input logic      busy,
  input logic      done,
  input logic      in_valid,
  input logic      out_valid
);

  int   error_count = 0;
  logic start_write;

  // Accepted START write in its completing cycle
  assign start_write = psel && penable && pwrite && (paddr == ADDR_CTRL)
                     && pwdata[0] && !pslverr;

  a_reset_values: assert property (@(posedge clk)
    rst |=> !busy && !done && !out_valid && !pslverr && (prdata == '0))
  else
  begin
    error_count++;
    $error("Status or bus outputs not at their reset values");
  end

  a_done_edge: assert property (@(posedge clk) disable iff (rst)
    $past(start_write, 4) |-> done && !busy)
  else
  begin
    error_count++;
    $error("done not set four edges after START");
  end

  a_busy_window: assert property (@(posedge clk) disable iff (rst)
    ($past(start_write, 2) || $past(start_write, 3)) |-> busy && !done)
  else
  begin
    error_count++;
    $error("busy low inside the computation window");
  end

  // busy and done only rise as a result of an accepted START
  a_busy_start: assert property (@(posedge clk) disable iff (rst)
    $rose(busy) |-> $past(start_write, 2))
  else
  begin
    error_count++;
    $error("busy rose without a START two edges before");
  end

  a_done_start: assert property (@(posedge clk) disable iff (rst)
    $rose(done) |-> $past(start_write, 4))
  else
  begin
    error_count++;
    $error("done rose without a START four edges before");
  end

  a_core_latency: assert property (@(posedge clk) disable iff (rst)
    out_valid == $past(in_valid, 2))
  else
  begin
    error_count++;
    $error("Core out_valid does not follow in_valid by two cycles");
  end

  a_bus_response: assert property (@(posedge clk) disable iff (rst)
    pready && (!pslverr || (psel && penable)))
  else
  begin
    error_count++;
    $error("pready low or pslverr outside an enable phase");
  end

endmodule

bind mod241_apb_top mod241_props i_mod241_props (
  .clk       (clk),
  .rst       (rst),
  .psel      (psel),
  .penable   (penable),
  .pwrite    (pwrite),
  .paddr     (paddr),
  .pwdata    (pwdata),
  .prdata    (prdata),
  .pready    (pready),
  .pslverr   (pslverr),
  .busy      (ctrl_if.busy),
  .done      (ctrl_if.done),
  .in_valid  (core_in_valid),
  .out_valid (core_out_valid)
);

`default_nettype wire

// File: testbench/tb_mod241_apb.sv
`default_nettype none

module tb_mod241_apb import mod241_pkg::*; ();

  localparam int NUM_RANDOM   = 200;
  localparam int NUM_MULTIPLE = 10;
  // Random, corner and directed operands
  localparam int NUM_OPERANDS = NUM_RANDOM + 2 * NUM_MULTIPLE + 8;
  // Words, status reads, START, polls and the result read
  localparam int ACCESSES_PER_OPERAND = 20;
  localparam int MAX_POLLS = 10;
  localparam int WATCHDOG_CYCLES = NUM_OPERANDS * ACCESSES_PER_OPERAND * 20 + 1000;

  logic      clk = 1'b0;
  logic      rst = 1'b1;
  logic      psel = 1'b0;
  logic      penable = 1'b0;
  logic      pwrite = 1'b0;
  apb_addr_t paddr = '0;
  apb_data_t pwdata = '0;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;

  logic [31:0] lfsr = 32'd99873;

  mod241_apb_top i_mod241_apb_top (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #5 clk = ~clk;

  task automatic report_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
    $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
    $display("TEST FAILED");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "Run aborted");
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_words(output logic [127:0] value);
    value = '0;
    for (int i = 0; i < 128; i++)
    begin
      lfsr  = lfsr_step(lfsr);
      value = {value[126:0], lfsr[0]};
    end
  endtask

  // Operand is the low 100 bits of the four words
  function automatic residue_t expected_residue(input logic [127:0] words);
    return residue_t'(words[99:0] % 100'd241);
  endfunction

  task automatic bus_access(input logic write, input apb_addr_t addr,
                            input apb_data_t data, output apb_data_t rdata,
                            output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    // Sampled away from the completing edge
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    assert (pready) else report_mismatch("pready", 128'(pready), 128'h1);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_reg(input apb_addr_t addr, input apb_data_t data,
                           input logic exp_err);
    apb_data_t rdata;
    logic      err;
    bus_access(1'b1, addr, data, rdata, err);
    assert (err == exp_err) else report_mismatch("pslverr", 128'(err), 128'(exp_err));
  endtask

  task automatic check_reg(input apb_addr_t addr, input apb_data_t exp, input string name);
    apb_data_t rdata;
    logic      err;
    bus_access(1'b0, addr, '0, rdata, err);
    assert (!err) else report_mismatch("pslverr", 128'(err), 128'h0);
    assert (rdata == exp) else report_mismatch(name, 128'(rdata), 128'(exp));
  endtask

  task automatic load_words(input logic [127:0] words, input int first, input int last);
    for (int i = first; i <= last; i++)
    begin
      write_reg(ADDR_OPERAND, words[32 * i +: 32], 1'b0);
      // done drops at the first word, loaded rises at the fourth
      check_reg(ADDR_STATUS, (i == 3) ? 32'h4 : 32'h0, "status");
    end
  endtask

  task automatic wait_done();
    apb_data_t status;
    logic      err;
    int        polls;
    polls  = 0;
    status = '0;
    while (!status[STAT_DONE] && polls < MAX_POLLS)
    begin
      bus_access(1'b0, ADDR_STATUS, '0, status, err);
      polls++;
    end
    assert (status[STAT_DONE]) else abort_run("done did not rise after START");
    assert (status == 32'h2) else report_mismatch("status", 128'(status), 128'h2);
  endtask

  task automatic reduce_operand(input logic [127:0] words);
    load_words(words, 0, 3);
    write_reg(ADDR_CTRL, 32'h1, 1'b0);
    wait_done();
    check_reg(ADDR_RESULT, 32'(expected_residue(words)), "result");
  endtask

  always @(negedge clk)
  begin
    if (i_mod241_apb_top.i_mod241_props.error_count != 0)
      abort_run("A bound timing or reset assertion failed");
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run("Watchdog expired before all tests finished");
  end

  initial
  begin
    logic [127:0] words;
    logic [127:0] fill;
    logic [99:0]  k;
    apb_data_t    rdata;
    logic         err;

    repeat (4) @(posedge clk);
    rst <= 1'b0;

    check_reg(ADDR_STATUS, 32'h0, "status");
    write_reg(ADDR_CTRL, 32'h1, 1'b1);
    check_reg(ADDR_STATUS, 32'h0, "status");

    bus_access(1'b0, 8'h10, '0, rdata, err);
    assert (err) else report_mismatch("pslverr", 128'(err), 128'h1);
    write_reg(8'hFC, 32'h1, 1'b1);

    // Three words are not enough for START
    random_words(words);
    load_words(words, 0, 2);
    write_reg(ADDR_CTRL, 32'h1, 1'b1);
    check_reg(ADDR_STATUS, 32'h0, "status");
    load_words(words, 3, 3);
    write_reg(ADDR_CTRL, 32'h1, 1'b0);
    wait_done();
    check_reg(ADDR_RESULT, 32'(expected_residue(words)), "result");

    // Operand write lands while busy
    random_words(words);
    load_words(words, 0, 3);
    write_reg(ADDR_CTRL, 32'h1, 1'b0);
    write_reg(ADDR_OPERAND, 32'hFFFF_FFFF, 1'b1);
    wait_done();
    check_reg(ADDR_RESULT, 32'(expected_residue(words)), "result");

    // Second START while busy
    random_words(words);
    load_words(words, 0, 3);
    write_reg(ADDR_CTRL, 32'h1, 1'b0);
    write_reg(ADDR_CTRL, 32'h1, 1'b1);
    wait_done();
    check_reg(ADDR_RESULT, 32'(expected_residue(words)), "result");

    reduce_operand('0);
    reduce_operand('1);

    for (int i = 0; i < NUM_MULTIPLE; i++)
    begin
      random_words(fill);
      if (i == 0)
        k = 100'd1;
      else if (i == 1)
        k = {100{1'b1}} / 100'd241;
      else
        k = {8'h0, fill[91:1], 1'b1};
      // Upper bits of word 3 carry junk
      reduce_operand({fill[127:100], 100'd241 * k});
      reduce_operand({fill[127:100], 100'd241 * k - 100'd1});
    end

    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      random_words(words);
      reduce_operand(words);
    end

    if (i_mod241_apb_top.i_mod241_props.error_count != 0)
      abort_run("A bound timing or reset assertion failed");
    else
    begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: mod241_apb_top.f
hdl/mod241_pkg.sv
hdl/residue_ctrl_if.sv
hdl/chunk_residue.sv
hdl/x_100_mod_241.sv
hdl/operand_word_counter.sv
hdl/residue_fsm.sv
hdl/apb_regs.sv
hdl/mod241_apb_top.sv
testbench/mod241_props.sv
testbench/tb_mod241_apb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mod241_apb
FILELIST  ?= mod241_apb_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= TEST PASSED

BIN := $(BUILD_DIR)/$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

# Pass only when the pass line appears in the simulation output
run: $(BIN)
	@out="$$($(BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(BUILD_DIR)
